// ==== sources.f ====
panel_pkg.sv
sequencer_pkg.sv
command_decode.sv
scan_sequencer.sv
nixie_scan.sv
ms6205_writer.sv
keypad_scan.sv
panel_top.sv
tb_panel.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f sources.f --top-module tb_panel
	./obj_dir/Vtb_panel | tee $(LOG)
	grep -q "All checks passed" $(LOG)
	! grep -q "Checks failed" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module tb_panel

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_panel.sv ====
module tb_panel;

	localparam int RESET_CYCLES = 10;
	localparam int FRAME_BUDGET = 48;  // 47 frames over all tests, each under 30 cycles.
	localparam int CYCLE_LIMIT = FRAME_BUDGET * 30 + RESET_CYCLES;

	logic clock_1us, rst, enable, cmd_valid;
	panel_pkg::cmd_opcode_t cmd_opcode;
	logic [3:0] cmd_index;
	logic [7:0] cmd_data;
	logic [3:0] key_rows = '0;
	logic [7:0] panel_bus;
	logic in12_write_cathode, in12_write_anode, keyboard_write, keyboard_read;
	logic ms6205_write_addr_n, ms6205_write_data_n, in12_clear_n, key_valid;
	sequencer_pkg::seq_state_t state;
	panel_pkg::key_code_t key_code;

	int checks = 0;
	int errors = 0;
	int cycle_count = 0;
	int exp_tube = panel_pkg::TUBE_COUNT - 1;  // tube shown by the last frame.
	logic [15:0] lfsr = 16'd54;
	logic [3:0] model_digits [panel_pkg::TUBE_COUNT];
	logic [3:0] pressed [panel_pkg::TUBE_COUNT];  // pressed rows per column.
	logic model_pending = 1'b0;
	logic [7:0] model_addr, model_char;
	int cath_cnt, anode_cnt, colw_cnt, read_cnt, maddr_cnt, mdata_cnt, valid_cnt;
	logic [7:0] cath_bus, anode_bus, col_bus, maddr_bus, mdata_bus;
	logic [7:0] col_latch = '0;  // the external column latch.
	logic [3:0] rows_next = '0;
	panel_pkg::key_code_t key_seen;

	panel_top dut (.*);

	initial begin
		clock_1us = 1'b0;
		forever #20 clock_1us = ~clock_1us;
	end

	always @(posedge clock_1us) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus monitor and key matrix
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [3:0] rows_for_column(logic [7:0] col);
		logic [3:0] rows;
		int c;
		rows = '0;
		for (c = 0; c < panel_pkg::TUBE_COUNT; c++) begin
			if (col[c]) rows = rows | pressed[c];
		end
		return rows;
	endfunction

	always @(negedge clock_1us) begin
		if (!rst) begin
			if (in12_write_cathode) begin
				cath_cnt++;
				cath_bus = panel_bus;
				check_state(state, sequencer_pkg::ST_CATHODES, "state at cathode strobe");
			end
			if (in12_write_anode) begin
				anode_cnt++;
				anode_bus = panel_bus;
				check_state(state, sequencer_pkg::ST_ANODES, "state at anode strobe");
			end
			if (keyboard_write) begin
				colw_cnt++;
				col_bus = panel_bus;
				col_latch = panel_bus;
				check_state(state, sequencer_pkg::ST_KEY_WRITE, "state at column strobe");
			end
			if (keyboard_read) begin
				read_cnt++;
				check_state(state, sequencer_pkg::ST_KEY_READ, "state at read strobe");
			end
			if (!ms6205_write_addr_n) begin
				maddr_cnt++;
				maddr_bus = panel_bus;
			end
			if (!ms6205_write_data_n) begin
				mdata_cnt++;
				mdata_bus = panel_bus;
			end
			if (key_valid) begin
				valid_cnt++;
				key_seen = key_code;
			end
		end
		rows_next = rows_for_column(col_latch);
	end

	always @(posedge clock_1us) key_rows <= rows_next;  // switches close onto the rows.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// random source and compare tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// x^16 + x^14 + x^13 + x^11 + 1, new bit shifted in at the bottom.
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [7:0] random_bits(int n);
		logic [7:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic check_state(sequencer_pkg::seq_state_t got, sequencer_pkg::seq_state_t exp,
		string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic check_bus(logic [7:0] got, logic [7:0] exp, string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_key(panel_pkg::key_code_t got, panel_pkg::key_code_t exp, string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(logic got, logic exp, string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(int got, int exp, string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("Mismatch at %0t: %0d %s seen, expected %0d", $time, got, what, exp);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and frame checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic send_command(panel_pkg::cmd_opcode_t op, logic [3:0] idx, logic [7:0] data);
		int k;
		@(posedge clock_1us);
		cmd_valid <= 1'b1;
		cmd_opcode <= op;
		cmd_index <= idx;
		cmd_data <= data;
		@(posedge clock_1us);
		cmd_valid <= 1'b0;
		cmd_opcode <= panel_pkg::OP_NOP;
		case (op)
			panel_pkg::OP_SET_DIGIT: begin
				if (idx < panel_pkg::TUBE_COUNT) model_digits[idx] = data[3:0];
			end
			panel_pkg::OP_SET_CHAR: begin
				model_pending = 1'b1;  // a newer character replaces the queued one.
				model_addr = {4'h0, idx};
				model_char = data;
			end
			panel_pkg::OP_CLEAR: begin
				for (k = 0; k < panel_pkg::TUBE_COUNT; k++) model_digits[k] = panel_pkg::DIGIT_BLANK;
			end
			default: begin
			end
		endcase
	endtask

	task automatic run_frame();
		cath_cnt = 0;
		anode_cnt = 0;
		colw_cnt = 0;
		read_cnt = 0;
		maddr_cnt = 0;
		mdata_cnt = 0;
		valid_cnt = 0;
		exp_tube = (exp_tube == panel_pkg::TUBE_COUNT - 1) ? 0 : exp_tube + 1;
		@(posedge clock_1us);
		enable <= 1'b1;
		do @(negedge clock_1us); while (state != sequencer_pkg::ST_HOLD);
		@(posedge clock_1us);
		enable <= 1'b0;  // the falling enable starts the key read.
		do @(negedge clock_1us); while (state != sequencer_pkg::ST_IDLE);
		@(posedge clock_1us);
	endtask

	task automatic verify_frame();
		logic [3:0] rows;
		int low;
		int r;
		rows = pressed[exp_tube];
		check_count(cath_cnt, 1, "cathode strobes");
		check_count(anode_cnt, 1, "anode strobes");
		check_count(colw_cnt, 1, "column strobes");
		check_count(read_cnt, 1, "read strobes");
		check_bus(cath_bus, {4'h0, model_digits[exp_tube]}, "cathode bus");
		check_bus(anode_bus, 8'h01 << exp_tube, "anode bus");
		check_bus(col_bus, 8'h01 << exp_tube, "column bus");
		check_count(maddr_cnt, model_pending ? 1 : 0, "MS6205 address pulses");
		check_count(mdata_cnt, model_pending ? 1 : 0, "MS6205 data pulses");
		if (model_pending) begin
			check_bus(maddr_bus, model_addr, "MS6205 address bus");
			check_bus(mdata_bus, model_char, "MS6205 data bus");
			model_pending = 1'b0;
		end
		check_count(valid_cnt, (rows != 0) ? 1 : 0, "key valid pulses");
		if (rows != 0) begin
			low = 0;
			for (r = panel_pkg::ROW_COUNT - 1; r >= 0; r--) if (rows[r]) low = r;
			check_key(key_seen, panel_pkg::key_code_t'(exp_tube * 4 + low), "key code");
		end
		check_state(state, sequencer_pkg::ST_IDLE, "state after frame");
	endtask

	task automatic run_checked_frames(int n);
		repeat (n) begin
			run_frame();
			verify_frame();
		end
	endtask

	task automatic report_test(string name, int first);
		if (errors == first) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - first);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_reset();
		int first;
		int k;
		first = errors;
		for (k = 0; k < panel_pkg::TUBE_COUNT; k++) begin
			model_digits[k] = panel_pkg::DIGIT_BLANK;
			pressed[k] = '0;
		end
		repeat (RESET_CYCLES / 2) @(posedge clock_1us);
		@(negedge clock_1us);
		check_bit(in12_clear_n, 1'b0, "in12_clear_n in reset");
		check_bit(in12_write_cathode | in12_write_anode, 1'b0, "tube strobes in reset");
		check_bit(keyboard_write | keyboard_read, 1'b0, "keyboard strobes in reset");
		check_bit(ms6205_write_addr_n & ms6205_write_data_n, 1'b1, "MS6205 outputs in reset");
		check_bit(key_valid, 1'b0, "key_valid in reset");
		check_state(state, sequencer_pkg::ST_IDLE, "state in reset");
		repeat (RESET_CYCLES - RESET_CYCLES / 2) @(posedge clock_1us);
		rst <= 1'b0;
		@(negedge clock_1us);
		check_bit(in12_clear_n, 1'b1, "in12_clear_n after reset");
		run_checked_frames(1);  // blank digit on tube 0.
		report_test("reset", first);
	endtask

	task automatic test_digits();
		int first;
		int k;
		logic [3:0] values [panel_pkg::TUBE_COUNT];
		first = errors;
		values = '{4'd3, 4'd1, 4'd4, 4'd1, 4'd5, 4'd9};
		for (k = 0; k < panel_pkg::TUBE_COUNT; k++) begin
			send_command(panel_pkg::OP_SET_DIGIT, 4'(k), {4'hA, values[k]});  // high nibble ignored.
		end
		run_checked_frames(panel_pkg::TUBE_COUNT);
		report_test("digits", first);
	endtask

	task automatic test_clear();
		int first;
		first = errors;
		send_command(panel_pkg::OP_CLEAR, 4'd0, 8'h00);
		send_command(panel_pkg::OP_SET_DIGIT, 4'd7, 8'h03);
		send_command(panel_pkg::OP_SET_DIGIT, 4'd12, 8'h07);  // low three bits point at tube 4.
		run_checked_frames(panel_pkg::TUBE_COUNT);
		report_test("clear", first);
	endtask

	task automatic test_ms6205();
		int first;
		first = errors;
		send_command(panel_pkg::OP_SET_CHAR, 4'd9, 8'h41);
		run_checked_frames(2);
		send_command(panel_pkg::OP_SET_CHAR, 4'd2, 8'h30);
		send_command(panel_pkg::OP_SET_CHAR, 4'd5, 8'h5A);
		run_checked_frames(1);
		report_test("ms6205", first);
	endtask

	task automatic test_keypad();
		int first;
		first = errors;
		pressed[3] = 4'b1100;  // rows 2 and 3 down, so row 2 is reported.
		run_checked_frames(panel_pkg::TUBE_COUNT);
		pressed[3] = 4'b0000;
		run_checked_frames(1);
		report_test("keypad", first);
	endtask

	task automatic test_random();
		int first;
		int n;
		int k;
		int col;
		logic [3:0] idx;
		logic [7:0] data;
		first = errors;
		for (n = 0; n < 24; n++) begin
			idx = 4'(random_bits(3));  // 6 and 7 exercise the range check.
			data = random_bits(8);
			send_command(panel_pkg::OP_SET_DIGIT, idx, data);
			if (random_bits(1) == 8'd1) begin
				idx = 4'(random_bits(4));
				data = random_bits(8);
				send_command(panel_pkg::OP_SET_CHAR, idx, data);
			end
			for (k = 0; k < panel_pkg::TUBE_COUNT; k++) pressed[k] = '0;
			col = int'(random_bits(3));
			if (col < panel_pkg::TUBE_COUNT) pressed[col] = 4'(random_bits(4));
			run_checked_frames(1);
		end
		report_test("random", first);
	endtask

	initial begin
		rst = 1'b1;
		enable = 1'b0;
		cmd_valid = 1'b0;
		cmd_opcode = panel_pkg::OP_NOP;
		cmd_index = '0;
		cmd_data = '0;
		test_reset();
		test_digits();
		test_clear();
		test_ms6205();
		test_keypad();
		test_random();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== panel_top.sv ====
module panel_top (
	input  logic                               clock_1us,
	input  logic                               rst,
	input  logic                               enable,
	input  logic                               cmd_valid,
	input  panel_pkg::cmd_opcode_t             cmd_opcode,
	input  logic [3:0]                         cmd_index,
	input  logic [7:0]                         cmd_data,
	input  logic [panel_pkg::ROW_COUNT-1:0]    key_rows,
	output logic [panel_pkg::BUS_WIDTH-1:0]    panel_bus,
	output logic                               in12_write_cathode,
	output logic                               in12_write_anode,
	output logic                               keyboard_write,
	output logic                               keyboard_read,
	output logic                               ms6205_write_addr_n,
	output logic                               ms6205_write_data_n,
	output logic                               in12_clear_n,
	output sequencer_pkg::seq_state_t          state,
	output logic                               key_valid,
	output panel_pkg::key_code_t               key_code
);

	logic [panel_pkg::TUBE_COUNT-1:0][3:0] digits;
	logic char_load, char_pending, index_step, mc_addr_fire, mc_data_fire;
	logic [7:0] char_addr, char_value, pend_addr, pend_char;
	logic [2:0] tube_index;
	logic [panel_pkg::BUS_WIDTH-1:0] cathode_value, anode_value, column_value;

	assign in12_clear_n = ~rst;  // tube latches clear together with the core.

	command_decode u_decode (.clock_1us, .rst, .cmd_valid, .cmd_opcode, .cmd_index,
		.cmd_data, .digits, .char_load, .char_addr, .char_value);

	scan_sequencer u_sequencer (.clock_1us, .rst, .enable, .char_pending, .pend_addr,
		.pend_char, .cathode_value, .anode_value, .column_value, .state, .panel_bus,
		.in12_write_cathode, .in12_write_anode, .keyboard_write, .keyboard_read,
		.index_step, .mc_addr_fire, .mc_data_fire);

	nixie_scan u_nixie (.clock_1us, .rst, .index_step, .digits, .tube_index,
		.cathode_value, .anode_value);

	ms6205_writer u_ms6205 (.clock_1us, .rst, .char_load, .char_addr, .char_value,
		.mc_addr_fire, .mc_data_fire, .char_pending, .pend_addr, .pend_char,
		.ms6205_write_addr_n, .ms6205_write_data_n);

	keypad_scan u_keypad (.clock_1us, .rst, .tube_index, .keyboard_read, .key_rows,
		.column_value, .key_valid, .key_code);

endmodule

// ==== keypad_scan.sv ====
module keypad_scan (
	input  logic                                  clock_1us,
	input  logic                                  rst,
	input  logic [2:0]                            tube_index,
	input  logic                                  keyboard_read,
	input  logic [panel_pkg::ROW_COUNT-1:0]       key_rows,
	output logic [panel_pkg::BUS_WIDTH-1:0]       column_value,
	output logic                                  key_valid,
	output panel_pkg::key_code_t                  key_code
);

	logic [1:0] low_row;
	logic any_row;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// column drive
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// columns follow the tube index, so one column is scanned per frame.
	assign column_value = panel_pkg::BUS_WIDTH'(1) << tube_index;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// row sampling
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign any_row = |key_rows;

	// the lowest pressed row wins when several are down.
	always_comb begin
		low_row = 2'd0;
		for (int i = panel_pkg::ROW_COUNT - 1; i >= 0; i--) begin
			if (key_rows[i]) begin
				low_row = 2'(i);
			end
		end
	end

	always_ff @(posedge clock_1us) begin
		if (rst) begin
			key_valid <= 1'b0;
		end else begin
			key_valid <= keyboard_read && any_row;  // single sample, no debounce.
		end
	end

	// code is column times four plus row.
	always_ff @(posedge clock_1us) begin
		if (keyboard_read && any_row) begin
			key_code <= {tube_index, low_row};
		end
	end

endmodule

// ==== ms6205_writer.sv ====
module ms6205_writer (
	input  logic        clock_1us,
	input  logic        rst,
	input  logic        char_load,
	input  logic [7:0]  char_addr,
	input  logic [7:0]  char_value,
	input  logic        mc_addr_fire,
	input  logic        mc_data_fire,
	output logic        char_pending,
	output logic [7:0]  pend_addr,
	output logic [7:0]  pend_char,
	output logic        ms6205_write_addr_n,
	output logic        ms6205_write_data_n
);

	logic addr_fire_q;
	logic data_fire_q;
	logic addr_pulse;
	logic data_pulse;
	logic data_rise;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write pulses
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign data_rise = mc_data_fire && !data_fire_q;

	always_ff @(posedge clock_1us) begin
		if (rst) begin
			addr_fire_q <= 1'b0;
			data_fire_q <= 1'b0;
			addr_pulse <= 1'b0;
			data_pulse <= 1'b0;
		end else begin
			addr_fire_q <= mc_addr_fire;
			data_fire_q <= mc_data_fire;
			addr_pulse <= mc_addr_fire && !addr_fire_q;  // one cycle per rising edge.
			data_pulse <= data_rise;
		end
	end

	assign ms6205_write_addr_n = ~addr_pulse;
	assign ms6205_write_data_n = ~data_pulse;

	// one pending slot, a later load simply replaces it.
	always_ff @(posedge clock_1us) begin
		if (rst) begin
			char_pending <= 1'b0;
		end else if (char_load) begin
			char_pending <= 1'b1;
		end else if (data_rise) begin
			char_pending <= 1'b0;
		end
	end

	always_ff @(posedge clock_1us) begin
		if (char_load) begin
			pend_addr <= char_addr;
			pend_char <= char_value;
		end
	end

	a_data_after_addr: assert property (@(posedge clock_1us) disable iff (rst)
		!ms6205_write_data_n |-> $past(!ms6205_write_addr_n, sequencer_pkg::PHASE_CYCLES));

endmodule

// ==== nixie_scan.sv ====
module nixie_scan (
	input  logic                                    clock_1us,
	input  logic                                    rst,
	input  logic                                    index_step,
	input  logic [panel_pkg::TUBE_COUNT-1:0][3:0]   digits,
	output logic [2:0]                              tube_index,
	output logic [panel_pkg::BUS_WIDTH-1:0]         cathode_value,
	output logic [panel_pkg::BUS_WIDTH-1:0]         anode_value
);

	logic index_at_last;

	assign index_at_last = tube_index == 3'(panel_pkg::TUBE_COUNT - 1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tube index
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// starting on the last tube makes the first frame land on tube 0.
	always_ff @(posedge clock_1us) begin
		if (rst) begin
			tube_index <= 3'(panel_pkg::TUBE_COUNT - 1);
		end else if (index_step) begin
			if (index_at_last) begin
				tube_index <= 3'd0;
			end else begin
				tube_index <= tube_index + 3'd1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// latch values
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// cathode decoder takes BCD in the low nibble.
	always_comb begin
		cathode_value = '0;
		cathode_value[3:0] = digits[tube_index];
	end

	// one anode driver on at a time, held by the latch until the next frame.
	assign anode_value = panel_pkg::BUS_WIDTH'(1) << tube_index;

	a_index_range: assert property (@(posedge clock_1us) disable iff (rst)
		tube_index < 3'(panel_pkg::TUBE_COUNT));

endmodule

// ==== scan_sequencer.sv ====
module scan_sequencer (
	input  logic                               clock_1us,
	input  logic                               rst,
	input  logic                               enable,
	input  logic                               char_pending,
	input  logic [7:0]                         pend_addr,
	input  logic [7:0]                         pend_char,
	input  logic [panel_pkg::BUS_WIDTH-1:0]    cathode_value,
	input  logic [panel_pkg::BUS_WIDTH-1:0]    anode_value,
	input  logic [panel_pkg::BUS_WIDTH-1:0]    column_value,
	output sequencer_pkg::seq_state_t          state,
	output logic [panel_pkg::BUS_WIDTH-1:0]    panel_bus,
	output logic                               in12_write_cathode,
	output logic                               in12_write_anode,
	output logic                               keyboard_write,
	output logic                               keyboard_read,
	output logic                               index_step,
	output logic                               mc_addr_fire,
	output logic                               mc_data_fire
);

	localparam int PW = sequencer_pkg::PHASE_WIDTH;

	sequencer_pkg::seq_state_t next_state;
	logic [PW-1:0] phase_cnt;
	logic [PW-1:0] next_phase;
	logic strobe_slot;
	logic mc_entry;
	logic mc_armed;
	logic mc_armed_next;
	logic [7:0] mc_addr_q;
	logic [7:0] mc_char_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// state and phase counter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		next_state = state;
		next_phase = '0;
		case (state)
			sequencer_pkg::ST_IDLE: if (enable) next_state = sequencer_pkg::ST_CATHODES;
			sequencer_pkg::ST_HOLD: if (!enable) next_state = sequencer_pkg::ST_KEY_READ;
			default: begin
				if (phase_cnt != PW'(sequencer_pkg::PHASE_CYCLES - 1)) begin
					next_phase = phase_cnt + 1'b1;
				end else if (state == sequencer_pkg::ST_KEY_READ) begin
					next_state = sequencer_pkg::ST_IDLE;
				end else begin
					// latch phases run in enum order and end in ST_HOLD.
					next_state = sequencer_pkg::seq_state_t'(state + 3'd1);
				end
			end
		endcase
	end

	always_ff @(posedge clock_1us) begin
		if (rst) begin
			state <= sequencer_pkg::ST_IDLE;
			phase_cnt <= '0;
		end else begin
			state <= next_state;
			phase_cnt <= next_phase;
		end
	end

	// the tube index moves on the edge that opens the cathode phase.
	assign index_step = (state == sequencer_pkg::ST_IDLE) && enable;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// strobes, one per phase in the strobe cycle
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign strobe_slot = next_phase == PW'(sequencer_pkg::STROBE_CYCLE);
	assign mc_entry = (next_state == sequencer_pkg::ST_MC_ADDR) &&
		(state != sequencer_pkg::ST_MC_ADDR);
	assign mc_armed_next = mc_entry ? char_pending : mc_armed;

	always_ff @(posedge clock_1us) begin
		if (rst) begin
			in12_write_cathode <= 1'b0;
			in12_write_anode <= 1'b0;
			keyboard_write <= 1'b0;
			keyboard_read <= 1'b0;
			mc_armed <= 1'b0;
		end else begin
			in12_write_cathode <= strobe_slot && (next_state == sequencer_pkg::ST_CATHODES);
			in12_write_anode <= strobe_slot && (next_state == sequencer_pkg::ST_ANODES);
			keyboard_write <= strobe_slot && (next_state == sequencer_pkg::ST_KEY_WRITE);
			keyboard_read <= strobe_slot && (next_state == sequencer_pkg::ST_KEY_READ);
			mc_armed <= mc_armed_next;
		end
	end

	// the writer registers these, so they lead the strobe cycle by one.
	assign mc_addr_fire = strobe_slot && mc_armed_next &&
		(next_state == sequencer_pkg::ST_MC_ADDR);
	assign mc_data_fire = strobe_slot && mc_armed_next &&
		(next_state == sequencer_pkg::ST_MC_DATA);

	// snapshot of the character so both MS6205 phases show the same one.
	always_ff @(posedge clock_1us) begin
		if (mc_entry) begin
			mc_addr_q <= pend_addr;
			mc_char_q <= pend_char;
		end
	end

	always_comb begin
		case (state)
			sequencer_pkg::ST_CATHODES:  panel_bus = cathode_value;
			sequencer_pkg::ST_ANODES:    panel_bus = anode_value;
			sequencer_pkg::ST_KEY_WRITE: panel_bus = column_value;
			sequencer_pkg::ST_MC_ADDR:   panel_bus = mc_addr_q;
			sequencer_pkg::ST_MC_DATA:   panel_bus = mc_char_q;
			default:                     panel_bus = '0;
		endcase
	end

	a_strobes_exclusive: assert property (@(posedge clock_1us) disable iff (rst)
		$onehot0({in12_write_cathode, in12_write_anode, keyboard_write, keyboard_read}));
	a_addr_fire_state: assert property (@(posedge clock_1us) disable iff (rst)
		mc_addr_fire |-> state == sequencer_pkg::ST_MC_ADDR);
	a_data_fire_state: assert property (@(posedge clock_1us) disable iff (rst)
		mc_data_fire |-> state == sequencer_pkg::ST_MC_DATA);

endmodule

// ==== command_decode.sv ====
module command_decode (
	input  logic                                    clock_1us,
	input  logic                                    rst,
	input  logic                                    cmd_valid,
	input  panel_pkg::cmd_opcode_t                  cmd_opcode,
	input  logic [3:0]                              cmd_index,
	input  logic [7:0]                              cmd_data,
	output logic [panel_pkg::TUBE_COUNT-1:0][3:0]   digits,
	output logic                                    char_load,
	output logic [7:0]                              char_addr,
	output logic [7:0]                              char_value
);

	logic index_in_range;

	// only the six tube slots exist, higher indices are dropped.
	assign index_in_range = cmd_index < 4'(panel_pkg::TUBE_COUNT);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// digit register file
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock_1us) begin
		if (rst) begin
			digits <= {panel_pkg::TUBE_COUNT{panel_pkg::DIGIT_BLANK}};
		end else if (cmd_valid) begin
			case (cmd_opcode)
				panel_pkg::OP_SET_DIGIT: begin
					if (index_in_range) begin
						digits[cmd_index[2:0]] <= cmd_data[3:0];
					end
				end
				panel_pkg::OP_CLEAR: begin
					digits <= {panel_pkg::TUBE_COUNT{panel_pkg::DIGIT_BLANK}};
				end
				default: begin
					digits <= digits;  // nop and char commands leave the tubes alone.
				end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// character hand-off to the MS6205 writer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock_1us) begin
		if (rst) begin
			char_load <= 1'b0;
		end else begin
			char_load <= cmd_valid && (cmd_opcode == panel_pkg::OP_SET_CHAR);
		end
	end

	// address and character ride along with the load pulse.
	always_ff @(posedge clock_1us) begin
		if (cmd_valid && (cmd_opcode == panel_pkg::OP_SET_CHAR)) begin
			char_addr <= {4'b0000, cmd_index};
			char_value <= cmd_data;
		end
	end

	a_opcode_known: assert property (@(posedge clock_1us) disable iff (rst)
		cmd_valid |-> !$isunknown({cmd_opcode, cmd_index}));

endmodule

// ==== sequencer_pkg.sv ====
package sequencer_pkg;

	// frame states in the order the sequencer walks them.
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CATHODES,
		ST_ANODES,
		ST_KEY_WRITE,
		ST_MC_ADDR,
		ST_MC_DATA,
		ST_HOLD,
		ST_KEY_READ
	} seq_state_t;

	// every latch phase has the same length.
	localparam int PHASE_CYCLES = 3;
	// strobe sits in this cycle of a phase, counted from zero.
	localparam int STROBE_CYCLE = 1;
	localparam int PHASE_WIDTH = 2;  // wide enough to count PHASE_CYCLES.

endpackage

// ==== panel_pkg.sv ====
package panel_pkg;

	// panel geometry.
	localparam int TUBE_COUNT = 6;  // six IN-12 tubes share one scan index.
	localparam int ROW_COUNT = 4;   // key rows read back through the bus latch.
	localparam int BUS_WIDTH = 8;

	// a BCD code above 9 leaves every cathode dark.
	localparam logic [3:0] DIGIT_BLANK = 4'd15;

	// host command opcodes.
	typedef enum logic [1:0] {
		OP_NOP,        // nothing happens.
		OP_SET_DIGIT,  // low nibble of cmd_data into digit cmd_index.
		OP_SET_CHAR,   // queue cmd_data for MS6205 address cmd_index.
		OP_CLEAR       // blank all tubes.
	} cmd_opcode_t;

	// column in the upper three bits, row in the lower two.
	typedef logic [4:0] key_code_t;

endpackage
